/* source/ptp_td_pkg.sv */
// widths, word indices, flag positions, message and receiver state types
package ptp_td_pkg;

    // input register stages on the serial line
    localparam int TD_SDI_PIPELINE = 2;

    localparam int TD_WORD_W      = 16;
    localparam int FNS_W          = 16;
    localparam int PERIOD_NS_W    = 8;
    localparam int LSB_NS_W       = 9;
    localparam int REL_NS_W       = 48;
    localparam int TOD_S_W        = 48;
    localparam int TOD_NS_W       = 30;
    localparam int MISMATCH_CNT_W = 2;

    localparam logic [TOD_NS_W-1:0] NS_PER_S = 30'd1_000_000_000;

    // flag bits inside frame words
    localparam int REL_STEP_BIT = 8;
    localparam int TOD_STEP_BIT = 15;

    typedef enum logic [3:0] {
        MSG_TIME   = 4'd0,
        MSG_OFFSET = 4'd1
    } td_msg_e;

    typedef enum logic [3:0] {
        WORD_CTRL  = 4'd0,
        TOD_NS_LO  = 4'd1,
        TOD_NS_HI  = 4'd2,
        TOD_S_0    = 4'd3,
        TOD_S_1    = 4'd4,
        TOD_S_2    = 4'd5,
        REL_NS_0   = 4'd8,
        REL_NS_1   = 4'd9,
        REL_NS_2   = 4'd10,
        PERIOD_FNS = 4'd11,
        PERIOD_NS  = 4'd12
    } td_word_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_MARK
    } td_rx_state_e;

endpackage

/* source/td_deserializer.sv */
// input pipeline and bit-level receiver producing indexed frame words
module td_deserializer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               td_sdi,
    output logic                               word_valid,
    output logic [ptp_td_pkg::TD_WORD_W-1:0]   word_data,
    output ptp_td_pkg::td_word_e               word_index,
    output ptp_td_pkg::td_msg_e                word_msg,
    output logic                               word_last
);
    import ptp_td_pkg::*;

    logic [TD_SDI_PIPELINE-1:0]   sdi_pipe;
    logic                         sdi;
    td_rx_state_e                 rx_state;
    logic [$clog2(TD_WORD_W)-1:0] bit_cnt;
    logic [TD_WORD_W-1:0]         shift_reg;
    logic [3:0]                   idx_cnt;
    td_msg_e                      msg_reg;

    assign sdi = sdi_pipe[TD_SDI_PIPELINE-1];

    always_ff @(posedge clk) begin
        sdi_pipe <= {sdi_pipe[TD_SDI_PIPELINE-2:0], td_sdi};
        word_valid <= 1'b0;

        case (rx_state)
            RX_IDLE: begin
                // low bit on an idle line opens a frame
                if (!sdi) begin
                    bit_cnt <= '0;
                    rx_state <= RX_DATA;
                end
            end
            RX_DATA: begin
                shift_reg <= {sdi, shift_reg[TD_WORD_W-1:1]};
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == $bits(bit_cnt)'(TD_WORD_W - 1)) begin
                    rx_state <= RX_MARK;
                end
            end
            RX_MARK: begin
                word_valid <= 1'b1;
                word_data <= shift_reg;
                word_index <= td_word_e'(idx_cnt);
                word_last <= sdi;
                word_msg <= msg_reg;
                // message type rides in word 0
                if (idx_cnt == 4'd0) begin
                    msg_reg <= td_msg_e'(shift_reg[3:0]);
                    word_msg <= td_msg_e'(shift_reg[3:0]);
                end
                if (sdi) begin
                    idx_cnt <= '0;
                    rx_state <= RX_IDLE;
                end else begin
                    idx_cnt <= idx_cnt + 1'b1;
                    bit_cnt <= '0;
                    rx_state <= RX_DATA;
                end
            end
            default: rx_state <= RX_IDLE;
        endcase

        if (rst) begin
            sdi_pipe <= '1;
            word_valid <= 1'b0;
            rx_state <= RX_IDLE;
            bit_cnt <= '0;
            idx_cnt <= '0;
        end
    end

endmodule

/* source/td_shadow_regs.sv */
// shadow registers for frame timestamps, offset and period, with valid and step flags
module td_shadow_regs (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              word_valid,
    input  logic [ptp_td_pkg::TD_WORD_W-1:0]                  word_data,
    input  ptp_td_pkg::td_word_e                              word_index,
    input  ptp_td_pkg::td_msg_e                               word_msg,
    input  logic                                              word_last,
    input  logic                                              rel_consumed,
    input  logic                                              tod_consumed,
    output logic [ptp_td_pkg::PERIOD_NS_W+ptp_td_pkg::FNS_W-1:0] period,
    output logic [ptp_td_pkg::REL_NS_W-1:0]                   rel_ns_shadow,
    output logic                                              rel_shadow_valid,
    output logic                                              rel_step_req,
    output logic [ptp_td_pkg::TOD_S_W-1:0]                    tod_s_shadow,
    output logic [ptp_td_pkg::TOD_NS_W-1:0]                   tod_ns_shadow,
    output logic                                              tod_shadow_valid,
    output logic                                              tod_step_req,
    output logic [ptp_td_pkg::LSB_NS_W-1:0]                   tod_offset_ns,
    output logic                                              frame_end
);
    import ptp_td_pkg::*;

    logic is_time;

    assign is_time = (word_msg == MSG_TIME);

    always_ff @(posedge clk) begin
        frame_end <= word_valid && word_last;

        if (rel_consumed) begin
            rel_shadow_valid <= 1'b0;
            rel_step_req <= 1'b0;
        end
        if (tod_consumed) begin
            tod_shadow_valid <= 1'b0;
            tod_step_req <= 1'b0;
        end

        if (word_valid) begin
            case (word_index)
                WORD_CTRL: rel_step_req <= rel_step_req | word_data[REL_STEP_BIT];
                TOD_NS_LO: begin
                    // any word 1 invalidates the held tod
                    tod_shadow_valid <= 1'b0;
                    if (is_time) begin
                        tod_ns_shadow[TD_WORD_W-1:0] <= word_data;
                    end else if (word_msg == MSG_OFFSET) begin
                        tod_offset_ns <= word_data[LSB_NS_W-1:0];
                    end
                end
                TOD_NS_HI: begin
                    if (is_time) begin
                        tod_ns_shadow[TOD_NS_W-1:TD_WORD_W] <=
                            word_data[TOD_NS_W-TD_WORD_W-1:0];
                        tod_step_req <= tod_step_req | word_data[TOD_STEP_BIT];
                    end
                end
                TOD_S_0: if (is_time) tod_s_shadow[15:0] <= word_data;
                TOD_S_1: if (is_time) tod_s_shadow[31:16] <= word_data;
                TOD_S_2: begin
                    if (is_time) begin
                        tod_s_shadow[47:32] <= word_data;
                        tod_shadow_valid <= 1'b1;
                    end
                end
                REL_NS_0: begin
                    rel_ns_shadow[15:0] <= word_data;
                    rel_shadow_valid <= 1'b0;
                end
                REL_NS_1: rel_ns_shadow[31:16] <= word_data;
                REL_NS_2: begin
                    rel_ns_shadow[47:32] <= word_data;
                    rel_shadow_valid <= 1'b1;
                end
                PERIOD_FNS: period[FNS_W-1:0] <= word_data;
                PERIOD_NS: period[PERIOD_NS_W+FNS_W-1:FNS_W] <= word_data[PERIOD_NS_W-1:0];
                default: ;
            endcase
        end

        if (rst) begin
            frame_end <= 1'b0;
            period <= '0;
            tod_offset_ns <= '0;
            rel_shadow_valid <= 1'b0;
            rel_step_req <= 1'b0;
            tod_shadow_valid <= 1'b0;
            tod_step_req <= 1'b0;
        end
    end

endmodule

/* source/ts_step_ctrl.sv */
// step versus compare decision with consecutive mismatch counter
module ts_step_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic apply,
    input  logic step_req,
    input  logic differ,
    output logic load
);
    import ptp_td_pkg::*;

    logic [MISMATCH_CNT_W-1:0] mismatch_cnt;
    logic                      load_pending;

    assign load = apply && (step_req || load_pending);

    always_ff @(posedge clk) begin
        if (apply) begin
            if (differ) begin
                // too many misses in a row, force a reload next time
                if (&mismatch_cnt) begin
                    load_pending <= 1'b1;
                    mismatch_cnt <= '0;
                end else begin
                    mismatch_cnt <= mismatch_cnt + 1'b1;
                end
            end else begin
                mismatch_cnt <= '0;
            end
            if (load) begin
                load_pending <= 1'b0;
            end
        end

        if (rst) begin
            mismatch_cnt <= '0;
            load_pending <= 1'b0;
        end
    end

endmodule

/* source/ts_rel_clock.sv */
// fractional accumulator and relative nanosecond counter
module ts_rel_clock (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic [ptp_td_pkg::PERIOD_NS_W+ptp_td_pkg::FNS_W-1:0] period,
    input  logic [ptp_td_pkg::REL_NS_W-1:0]                   rel_ns_shadow,
    input  logic                                              rel_shadow_valid,
    input  logic                                              rel_step_req,
    input  logic                                              frame_end,
    output logic [ptp_td_pkg::LSB_NS_W-1:0]                   lsb_ns,
    output logic [ptp_td_pkg::FNS_W-1:0]                      fns,
    output logic [ptp_td_pkg::REL_NS_W+ptp_td_pkg::FNS_W-1:0] ts_rel,
    output logic                                              ts_rel_step,
    output logic                                              rel_consumed
);
    import ptp_td_pkg::*;

    logic [LSB_NS_W+FNS_W-1:0] acc;
    logic [REL_NS_W-1:0]       rel_ns;
    logic                      apply;
    logic                      differ;
    logic                      load;

    assign lsb_ns = acc[LSB_NS_W+FNS_W-1:FNS_W];
    assign apply = frame_end && rel_shadow_valid;
    assign rel_consumed = apply;
    assign differ = rel_ns_shadow[REL_NS_W-1:LSB_NS_W] != rel_ns[REL_NS_W-1:LSB_NS_W];
    assign ts_rel = {rel_ns, fns};

    ts_step_ctrl u_step_ctrl (
        .clk      (clk),
        .rst      (rst),
        .apply    (apply),
        .step_req (rel_step_req),
        .differ   (differ),
        .load     (load)
    );

    always_ff @(posedge clk) begin
        acc <= acc + (LSB_NS_W+FNS_W)'(period);
        fns <= acc[FNS_W-1:0];
        rel_ns[LSB_NS_W-1:0] <= lsb_ns;
        ts_rel_step <= load;

        if (load) begin
            rel_ns[REL_NS_W-1:LSB_NS_W] <= rel_ns_shadow[REL_NS_W-1:LSB_NS_W];
        end else if (rel_ns[LSB_NS_W-1] && !lsb_ns[LSB_NS_W-1]) begin
            // carry out of the low bits
            rel_ns[REL_NS_W-1:LSB_NS_W] <= rel_ns[REL_NS_W-1:LSB_NS_W] + 1'b1;
        end

        if (rst) begin
            acc <= '0;
            fns <= '0;
            rel_ns <= '0;
            ts_rel_step <= 1'b0;
        end
    end

endmodule

/* source/ts_tod_clock.sv */
// seconds and nanoseconds time of day counter with offset, rollover and pps
module ts_tod_clock (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [ptp_td_pkg::LSB_NS_W-1:0]         lsb_ns,
    input  logic [ptp_td_pkg::FNS_W-1:0]            fns,
    input  logic [ptp_td_pkg::LSB_NS_W-1:0]         tod_offset_ns,
    input  logic [ptp_td_pkg::TOD_S_W-1:0]          tod_s_shadow,
    input  logic [ptp_td_pkg::TOD_NS_W-1:0]         tod_ns_shadow,
    input  logic                                    tod_shadow_valid,
    input  logic                                    tod_step_req,
    input  logic                                    frame_end,
    output logic [ptp_td_pkg::TOD_S_W+2+ptp_td_pkg::TOD_NS_W+ptp_td_pkg::FNS_W-1:0] ts_tod,
    output logic                                    ts_tod_step,
    output logic                                    pps,
    output logic                                    pps_str,
    output logic                                    tod_consumed
);
    import ptp_td_pkg::*;

    logic [TOD_S_W-1:0]  tod_s;
    logic [TOD_NS_W-1:0] tod_ns;
    logic [LSB_NS_W-1:0] ns_lo;
    logic                ns_carry;
    logic                ns_last;
    logic                apply;
    logic                differ;
    logic                load;

    assign ns_lo = lsb_ns + tod_offset_ns;
    assign ns_carry = tod_ns[LSB_NS_W-1] && !ns_lo[LSB_NS_W-1];
    // upper bits already at the last 512 ns block of the second
    assign ns_last = tod_ns[TOD_NS_W-1:LSB_NS_W] ==
        (TOD_NS_W-LSB_NS_W)'((NS_PER_S - 1'b1) >> LSB_NS_W);

    assign apply = frame_end && tod_shadow_valid;
    assign tod_consumed = apply;
    assign differ = (tod_s_shadow != tod_s) ||
        (tod_ns_shadow[TOD_NS_W-1:LSB_NS_W] != tod_ns[TOD_NS_W-1:LSB_NS_W]);
    assign ts_tod = {tod_s, 2'b00, tod_ns, fns};

    ts_step_ctrl u_step_ctrl (
        .clk      (clk),
        .rst      (rst),
        .apply    (apply),
        .step_req (tod_step_req),
        .differ   (differ),
        .load     (load)
    );

    always_ff @(posedge clk) begin
        pps <= 1'b0;
        tod_ns[LSB_NS_W-1:0] <= ns_lo;
        ts_tod_step <= load;

        // stretched pps drops halfway through the second
        if (tod_ns[TOD_NS_W-1]) begin
            pps_str <= 1'b0;
        end

        if (ns_carry) begin
            if (ns_last) begin
                tod_ns[TOD_NS_W-1:LSB_NS_W] <= '0;
                tod_s <= tod_s + 1'b1;
                pps <= 1'b1;
                pps_str <= 1'b1;
            end else begin
                tod_ns[TOD_NS_W-1:LSB_NS_W] <= tod_ns[TOD_NS_W-1:LSB_NS_W] + 1'b1;
            end
        end

        if (load) begin
            tod_s <= tod_s_shadow;
            tod_ns[TOD_NS_W-1:LSB_NS_W] <= tod_ns_shadow[TOD_NS_W-1:LSB_NS_W];
        end

        if (rst) begin
            tod_s <= '0;
            tod_ns <= '0;
            ts_tod_step <= 1'b0;
            pps <= 1'b0;
            pps_str <= 1'b0;
        end
    end

endmodule

/* source/ptp_td_leaf.sv */
// time distribution leaf top level, deserializer to shadow registers to both clocks
module ptp_td_leaf (
    input  logic        clk,
    input  logic        rst,
    input  logic        td_sdi,
    output logic [63:0] ts_rel,
    output logic        ts_rel_step,
    output logic [95:0] ts_tod,
    output logic        ts_tod_step,
    output logic        pps,
    output logic        pps_str
);
    import ptp_td_pkg::*;

    logic                         word_valid;
    logic [TD_WORD_W-1:0]         word_data;
    td_word_e                     word_index;
    td_msg_e                      word_msg;
    logic                         word_last;
    logic [PERIOD_NS_W+FNS_W-1:0] period;
    logic [REL_NS_W-1:0]          rel_ns_shadow;
    logic                         rel_shadow_valid;
    logic                         rel_step_req;
    logic                         rel_consumed;
    logic [TOD_S_W-1:0]           tod_s_shadow;
    logic [TOD_NS_W-1:0]          tod_ns_shadow;
    logic                         tod_shadow_valid;
    logic                         tod_step_req;
    logic                         tod_consumed;
    logic [LSB_NS_W-1:0]          tod_offset_ns;
    logic                         frame_end;
    logic [LSB_NS_W-1:0]          lsb_ns;
    logic [FNS_W-1:0]             fns;

    td_deserializer u_deserializer (
        .clk        (clk),
        .rst        (rst),
        .td_sdi     (td_sdi),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_index (word_index),
        .word_msg   (word_msg),
        .word_last  (word_last)
    );

    td_shadow_regs u_shadow_regs (
        .clk              (clk),
        .rst              (rst),
        .word_valid       (word_valid),
        .word_data        (word_data),
        .word_index       (word_index),
        .word_msg         (word_msg),
        .word_last        (word_last),
        .rel_consumed     (rel_consumed),
        .tod_consumed     (tod_consumed),
        .period           (period),
        .rel_ns_shadow    (rel_ns_shadow),
        .rel_shadow_valid (rel_shadow_valid),
        .rel_step_req     (rel_step_req),
        .tod_s_shadow     (tod_s_shadow),
        .tod_ns_shadow    (tod_ns_shadow),
        .tod_shadow_valid (tod_shadow_valid),
        .tod_step_req     (tod_step_req),
        .tod_offset_ns    (tod_offset_ns),
        .frame_end        (frame_end)
    );

    ts_rel_clock u_rel_clock (
        .clk              (clk),
        .rst              (rst),
        .period           (period),
        .rel_ns_shadow    (rel_ns_shadow),
        .rel_shadow_valid (rel_shadow_valid),
        .rel_step_req     (rel_step_req),
        .frame_end        (frame_end),
        .lsb_ns           (lsb_ns),
        .fns              (fns),
        .ts_rel           (ts_rel),
        .ts_rel_step      (ts_rel_step),
        .rel_consumed     (rel_consumed)
    );

    ts_tod_clock u_tod_clock (
        .clk              (clk),
        .rst              (rst),
        .lsb_ns           (lsb_ns),
        .fns              (fns),
        .tod_offset_ns    (tod_offset_ns),
        .tod_s_shadow     (tod_s_shadow),
        .tod_ns_shadow    (tod_ns_shadow),
        .tod_shadow_valid (tod_shadow_valid),
        .tod_step_req     (tod_step_req),
        .frame_end        (frame_end),
        .ts_tod           (ts_tod),
        .ts_tod_step      (ts_tod_step),
        .pps              (pps),
        .pps_str          (pps_str),
        .tod_consumed     (tod_consumed)
    );

endmodule

/* sim/tb_ptp_td_leaf.sv */
// testbench for the time distribution leaf with frame sender, directed tests and watchdog
module tb_ptp_td_leaf;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_FRAMES = 12;
    localparam int WORDS_PER_FRAME = 13;
    localparam int WATCHDOG_NS = (NUM_FRAMES * WORDS_PER_FRAME * 17 + 3000) * CLK_PERIOD * 2;
    localparam logic [29:0] NS_PER_S = 30'd1_000_000_000;
    localparam logic [3:0] MSG_TIME = 4'd0;
    localparam logic [3:0] MSG_OFFSET = 4'd1;
    localparam int SEL_REL_STEP = 0;
    localparam int SEL_TOD_STEP = 1;
    localparam int SEL_PPS = 2;

    logic        clk;
    logic        rst;
    logic        td_sdi;
    logic [63:0] ts_rel;
    logic        ts_rel_step;
    logic [95:0] ts_tod;
    logic        ts_tod_step;
    logic        pps;
    logic        pps_str;

    logic [31:0] lcg_state = 32'hf35b;
    logic [15:0] frame_words [0:15];
    logic [8:0]  offset;
    int          check_errors;
    int          other_errors;

    ptp_td_leaf u_ptp_td_leaf (
        .clk         (clk),
        .rst         (rst),
        .td_sdi      (td_sdi),
        .ts_rel      (ts_rel),
        .ts_rel_step (ts_rel_step),
        .ts_tod      (ts_tod),
        .ts_tod_step (ts_tod_step),
        .pps         (pps),
        .pps_str     (pps_str)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic watched(input int sel);
        case (sel)
            SEL_REL_STEP: return ts_rel_step;
            SEL_TOD_STEP: return ts_tod_step;
            default: return pps;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] expected);
        if (got !== expected) begin
            check_errors++;
            $display("Fail %0t %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic send_bit(input logic b);
        @(negedge clk);
        td_sdi = b;
    endtask

    // low marker then data lsb first
    task automatic send_word(input logic [15:0] data);
        send_bit(1'b0);
        for (int i = 0; i < 16; i++) begin
            send_bit(data[i]);
        end
    endtask

    task automatic send_frame(input int num_words);
        for (int w = 0; w < num_words; w++) begin
            send_word(frame_words[w]);
        end
        // high marker closes the frame
        send_bit(1'b1);
        send_bit(1'b1);
    endtask

    task automatic count_pulses(input int sel, input int cycles, output int pulses);
        pulses = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (watched(sel)) begin
                pulses++;
            end
        end
    endtask

    task automatic wait_for(input int sel, input int max_cycles, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!watched(sel) && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!watched(sel)) begin
            other_errors++;
            $display("%s did not pulse within %0d cycles", name, max_cycles);
        end
    endtask

    // offset message carrying the period and echoing the current rel upper bits
    task automatic send_period_frame(input logic [23:0] p, input logic [8:0] ofs);
        logic [47:0] rel_now;
        rel_now = {ts_rel[63:25], 9'h000};
        for (int i = 0; i < WORDS_PER_FRAME; i++) begin
            frame_words[i] = 16'h0000;
        end
        frame_words[0] = {12'h000, MSG_OFFSET};
        frame_words[1] = {7'h00, ofs};
        frame_words[8] = rel_now[15:0];
        frame_words[9] = rel_now[31:16];
        frame_words[10] = rel_now[47:32];
        frame_words[11] = p[15:0];
        frame_words[12] = {8'h00, p[23:16]};
        send_frame(WORDS_PER_FRAME);
        repeat (10) @(negedge clk);
    endtask

    // time frame whose tod fields match the frozen local tod
    task automatic send_rel_frame(input logic [47:0] rel_ns, input logic step,
                                  input int expected);
        int pulses;
        frame_words[0] = {7'h00, step, 4'h0, MSG_TIME};
        frame_words[1] = ts_tod[31:16];
        frame_words[2] = {2'b00, ts_tod[45:32]};
        frame_words[3] = ts_tod[63:48];
        frame_words[4] = ts_tod[79:64];
        frame_words[5] = ts_tod[95:80];
        frame_words[6] = 16'h0000;
        frame_words[7] = 16'h0000;
        frame_words[8] = rel_ns[15:0];
        frame_words[9] = rel_ns[31:16];
        frame_words[10] = rel_ns[47:32];
        send_frame(11);
        count_pulses(SEL_REL_STEP, 12, pulses);
        check_value("ts_rel_step pulses", 96'(pulses), 96'(expected));
    endtask

    task automatic test_reset();
        repeat (100) begin
            @(negedge clk);
            check_value("ts_rel", ts_rel, 0);
            check_value("ts_tod", ts_tod, 0);
            check_value("pps", pps, 0);
            check_value("ts_rel_step", ts_rel_step, 0);
            check_value("ts_tod_step", ts_tod_step, 0);
        end
    endtask

    task automatic test_period();
        logic [31:0] r;
        logic [23:0] p;
        logic [63:0] first;
        int          n;
        r = next_random();
        p = r[23:0];
        n = 200 + int'(r[31:24]);
        send_period_frame(p, offset);
        first = ts_rel;
        repeat (n) @(negedge clk);
        check_value("ts_rel delta", 64'(ts_rel - first), 64'(64'(n) * 64'(p)));
    endtask

    task automatic test_rel_step();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        logic [47:0] sent;
        logic [38:0] exp_upper;
        r_hi = next_random();
        r_lo = next_random();
        sent = {r_hi[15:0], r_lo};
        // zero period freezes both clocks
        send_period_frame(24'h000000, offset);
        send_rel_frame(sent, 1'b1, 1);
        exp_upper = sent[47:9];
        if (ts_rel[63:25] == exp_upper + 39'd1) begin
            exp_upper = exp_upper + 39'd1;
        end
        check_value("ts_rel[63:25]", ts_rel[63:25], exp_upper);
    endtask

    task automatic test_mismatch();
        logic [38:0] base;
        base = ts_rel[63:25];
        send_rel_frame({base, 9'h000}, 1'b0, 0);
        for (int i = 1; i <= 5; i++) begin
            send_rel_frame({base + 39'd1000, 9'h000}, 1'b0, (i == 5) ? 1 : 0);
        end
        check_value("ts_rel[63:25]", ts_rel[63:25], 39'(base + 39'd1000));
        send_rel_frame({base + 39'd1000, 9'h000}, 1'b0, 0);
    endtask

    task automatic test_tod_pps();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        logic [47:0] secs;
        logic [29:0] ns;
        int          pulses;
        r_hi = next_random();
        r_lo = next_random();
        offset = r_hi[24:16];
        secs = {r_hi[15:0], r_lo};
        ns = NS_PER_S - 30'd4096;
        // 8 ns period in 8.16 format
        send_period_frame(24'h080000, offset);
        frame_words[0] = {12'h000, MSG_TIME};
        frame_words[1] = ns[15:0];
        frame_words[2] = {1'b1, 1'b0, ns[29:16]};
        frame_words[3] = secs[15:0];
        frame_words[4] = secs[31:16];
        frame_words[5] = secs[47:32];
        send_frame(6);
        wait_for(SEL_TOD_STEP, 30, "ts_tod_step");
        count_pulses(SEL_TOD_STEP, 12, pulses);
        check_value("extra ts_tod_step pulses", 96'(pulses), 0);
        wait_for(SEL_PPS, 2000, "pps");
        check_value("ts_tod seconds", ts_tod[95:48], 48'(secs + 48'd1));
        check_value("ts_tod ns below 512 + offset", ts_tod[45:16] < 30'd512 + offset, 1);
        check_value("pps_str", pps_str, 1);
    endtask

    initial begin
        rst = 1'b1;
        td_sdi = 1'b1;
        offset = '0;
        check_errors = 0;
        other_errors = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_period();
        test_rel_step();
        test_mismatch();
        test_tod_pps();
        $display("errors: %0d value mismatches, %0d missing pulses", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* vlog.f */
source/ptp_td_pkg.sv
source/td_deserializer.sv
source/td_shadow_regs.sv
source/ts_step_ctrl.sv
source/ts_rel_clock.sv
source/ts_tod_clock.sv
source/ptp_td_leaf.sv
sim/tb_ptp_td_leaf.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f vlog.f --top-module tb_ptp_td_leaf -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"
if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
